// File: project.f
+incdir+src
src/bus_console_pkg.sv
src/panel_if.sv
src/display_if.sv
src/panel_input.sv
src/command_processor.sv
src/seven_seg_encoder.sv
src/display_driver.sv
src/bus_console_top.sv
test/bus_console_props.sv
test/bus_console_tb.sv

// File: Bender.yml
package:
  name: bus_console

sources:
  - target: any(rtl, test)
    include_dirs:
      - src
    files:
      - src/bus_console_pkg.sv
      - src/panel_if.sv
      - src/display_if.sv
      - src/panel_input.sv
      - src/command_processor.sv
      - src/seven_seg_encoder.sv
      - src/display_driver.sv
      - src/bus_console_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/bus_console_props.sv
      - test/bus_console_tb.sv

// File: test/bus_console_tb.sv
// Bus console testbench
// Presses buttons through configuration and run mode, predicts commands,
// strobes and digit patterns with a reference model, compares with the DUT

`timescale 1ns/1ns

`include "console_settings.svh"

module bus_console_tb;

	localparam int PERIOD      = 40;
	localparam int NUM_PRESSES = 60;
	localparam int TIMEOUT_NS  = (NUM_PRESSES * 8 + 8 + 200) * PERIOD;
	// seven-segment patterns from F down to 0
	localparam logic [16*7-1:0] SEG_TABLE = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77,
		7'h6F, 7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

	logic                  reset;  // board clock
	logic                  clk;    // asynchronous reset, active high
	logic                  button1, button2, button3;
	logic                  mode_switch, rw_switch1, rw_switch2;
	logic [`ADDR_LEN-1:0]  switch_array;
	logic [6:0]            display1_pin, display2_pin, display3_pin, display4_pin;
	logic [3:0]            display_val4;
	logic                  read1, write1, read2, write2;
	logic [`SLAVE_LEN-1:0] slave1, slave2;
	logic [`ADDR_LEN:0]    address1, address2;
	logic [`DATA_LEN-1:0]  data1, data2;
	logic [`BURST_LEN-1:0] burst_num1, burst_num2;

	bus_console_pkg::bus_cmd_t m_scratch, m_cmd1, m_cmd2;
	logic [2:0]                m_state;
	logic [1:0]                m_master;
	logic                      m_mode, m_rw1, m_rw2;
	logic [`ADDR_LEN-1:0]      m_sw;
	int                        n_rd1, n_wr1, n_rd2, n_wr2;      // expected strobe counts
	int                        rd1_cnt, wr1_cnt, rd2_cnt, wr2_cnt;
	int                        checks_req, checks_done, check_count, err_count;
	int                        test_errs, test_num, tests_failed;
	int                        assert_errs;
	integer                    seed;

	bus_console_top i_bus_console_top
	(
		.reset(reset), .clk(clk),
		.button1(button1), .button2(button2), .button3(button3),
		.mode_switch(mode_switch), .rw_switch1(rw_switch1), .rw_switch2(rw_switch2),
		.switch_array(switch_array),
		.display1_pin(display1_pin), .display2_pin(display2_pin),
		.display3_pin(display3_pin), .display4_pin(display4_pin),
		.display_val4(display_val4),
		.read1(read1), .write1(write1), .read2(read2), .write2(write2),
		.slave1(slave1), .address1(address1), .data1(data1), .burst_num1(burst_num1),
		.slave2(slave2), .address2(address2), .data2(data2), .burst_num2(burst_num2)
	);

	bind bus_console_top bus_console_props i_bus_console_props
	(
		.reset(reset), .clk(clk),
		.read1(read1), .write1(write1), .read2(read2), .write2(write2),
		.display_val4(display_val4)
	);

	initial reset = 1'b0;
	always #(PERIOD / 2) reset = ~reset;

	// strobes are single cycles so count them as they go by
	always @(negedge reset)
	begin
		if (read1) rd1_cnt++;
		if (write1) wr1_cnt++;
		if (read2) rd2_cnt++;
		if (write2) wr2_cnt++;
	end

	function automatic bus_console_pkg::bus_cmd_t power_up_cmd();
		bus_console_pkg::bus_cmd_t c;
		c.slave     = 2'd1;
		c.address   = '0;
		c.data      = '0;
		c.burst_num = 13'd1;
		return c;
	endfunction

	function automatic logic [`ADDR_LEN-1:0] random_switches();
		return `ADDR_LEN'($random(seed));
	endfunction

	// reference model for one operator press
	function automatic void model_press(input int btn, input logic [`ADDR_LEN-1:0] sw);
		m_sw = sw;
		if (m_mode)
		begin
			if (btn == 1 && m_rw1) n_rd1++;
			if (btn == 1 && !m_rw1) n_wr1++;
			if (btn == 2 && m_rw2) n_rd2++;
			if (btn == 2 && !m_rw2) n_wr2++;
			return;
		end
		case (m_state)
			bus_console_pkg::idle_config: m_state = bus_console_pkg::select_master;
			bus_console_pkg::select_master:
				if (btn == 3)
					m_state = bus_console_pkg::select_slave;
				else
					m_master = (m_master == 2'd1) ? 2'd2 : 2'd1;
			bus_console_pkg::select_slave:
				if (btn == 3)
					m_state = bus_console_pkg::select_address;
				else if (btn == 1)
					m_scratch.slave = (m_scratch.slave >= 2'd3) ? 2'd0 : m_scratch.slave + 2'd1;
				else
					m_scratch.slave = (m_scratch.slave <= 2'd1) ? 2'd3 : m_scratch.slave - 2'd1;
			bus_console_pkg::select_address:
			begin
				m_scratch.address = {1'b0, sw};
				m_state = bus_console_pkg::select_data;
			end
			bus_console_pkg::select_data:
			begin
				m_scratch.data = sw[7:0];
				m_state = bus_console_pkg::select_burst;
			end
			bus_console_pkg::select_burst:
			begin
				m_scratch.burst_num = (sw >= `BURST_MAX) ? 13'(`BURST_MAX) : 13'(sw);
				m_state = bus_console_pkg::finish;
			end
			default:
			begin
				if (m_master == 2'd1)
					m_cmd1 = m_scratch;
				else
					m_cmd2 = m_scratch;
				m_state   = bus_console_pkg::idle_config;
				m_master  = 2'd1;
				m_scratch = power_up_cmd();
			end
		endcase
	endfunction

	// digit values {d4, d3, d2, d1} for the modelled step
	function automatic logic [15:0] expected_digits();
		logic [3:0] v1;
		logic [3:0] v2;
		logic [3:0] v3;
		v1 = 4'h0;
		v2 = 4'h0;
		v3 = 4'h0;
		if (m_state == bus_console_pkg::select_master)
			v1 = {2'b00, m_master};
		else if (m_state == bus_console_pkg::select_slave)
			v1 = {2'b00, m_scratch.slave};
		else if (m_state >= bus_console_pkg::select_address &&
			m_state <= bus_console_pkg::select_burst)
		begin
			v1 = m_sw[3:0];
			v2 = m_sw[7:4];
			if (m_state != bus_console_pkg::select_data)
				v3 = m_sw[11:8];
		end
		return {1'b0, m_state, v3, v2, v1};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			$display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic compare_outputs();
		logic [15:0] d;
		d = expected_digits();
		check_value("slave1", m_cmd1.slave, slave1);
		check_value("address1", m_cmd1.address, address1);
		check_value("data1", m_cmd1.data, data1);
		check_value("burst_num1", m_cmd1.burst_num, burst_num1);
		check_value("slave2", m_cmd2.slave, slave2);
		check_value("address2", m_cmd2.address, address2);
		check_value("data2", m_cmd2.data, data2);
		check_value("burst_num2", m_cmd2.burst_num, burst_num2);
		check_value("display1_pin", SEG_TABLE[d[3:0]*7 +: 7], display1_pin);
		check_value("display2_pin", SEG_TABLE[d[7:4]*7 +: 7], display2_pin);
		check_value("display3_pin", SEG_TABLE[d[11:8]*7 +: 7], display3_pin);
		check_value("display4_pin", SEG_TABLE[d[15:12]*7 +: 7], display4_pin);
		check_value("display_val4", d[15:12], display_val4);
		check_value("read1 count", n_rd1, rd1_cnt);
		check_value("write1 count", n_wr1, wr1_cnt);
		check_value("read2 count", n_rd2, rd2_cnt);
		check_value("write2 count", n_wr2, wr2_cnt);
	endtask

	initial
	begin
		forever
		begin
			wait (checks_done < checks_req);
			compare_outputs();
			checks_done++;
		end
	end

	task automatic request_check();
		checks_req++;
		wait (checks_done == checks_req);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge reset);
		#5;
	endtask

	// hold 4 cycles, release 4 cycles, then compare
	task automatic press_button(input int btn, input logic [`ADDR_LEN-1:0] sw);
		switch_array = sw;
		button1 = (btn == 1);
		button2 = (btn == 2);
		button3 = (btn == 3);
		wait_cycles(4);
		button1 = 1'b0;
		button2 = 1'b0;
		button3 = 1'b0;
		wait_cycles(4);
		model_press(btn, sw);
		request_check();
	endtask

	task automatic set_mode(input logic run);
		mode_switch = run;
		m_mode = run;
		if (run)
		begin
			m_state   = bus_console_pkg::idle_config;
			m_master  = 2'd1;
			m_scratch = power_up_cmd();
		end
		wait_cycles(4);
		request_check();
	endtask

	task automatic set_rw(input logic rw1, input logic rw2);
		rw_switch1 = rw1;
		rw_switch2 = rw2;
		m_rw1 = rw1;
		m_rw2 = rw2;
	endtask

	// one full pass from idle where slave_btn 0 leaves the slave alone
	task automatic configure(input logic [1:0] master, input int slave_btn,
		input logic [`ADDR_LEN-1:0] addr, data, burst);
		press_button(3, m_sw);
		if (master == 2'd2)
			press_button(1, m_sw);
		press_button(3, m_sw);
		if (slave_btn != 0)
			press_button(slave_btn, m_sw);
		press_button(3, addr);
		press_button(3, addr);
		press_button(3, data);
		press_button(3, burst);
		press_button(3, burst);
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (test_errs == 0)
			$display("test %0d %s: ok", test_num, name);
		else
		begin
			$display("test %0d %s: %0d mismatches", test_num, name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	initial
	begin
		seed = 32'h9a06;
		clk = 1'b1;
		button1 = 1'b0;
		button2 = 1'b0;
		button3 = 1'b0;
		mode_switch = 1'b0;
		switch_array = '0;
		set_rw(1'b0, 1'b0);
		m_mode = 1'b0;
		m_sw = '0;
		m_state = bus_console_pkg::idle_config;
		m_master = 2'd1;
		m_scratch = power_up_cmd();
		m_cmd1 = power_up_cmd();
		m_cmd2 = power_up_cmd();
		repeat (8) @(posedge reset);
		#5 clk = 1'b0;
		wait_cycles(4);
		request_check();
		end_test("reset values");

		configure(2'd1, 1, random_switches(), random_switches(), random_switches());
		configure(2'd2, 2, random_switches(), random_switches(), random_switches());
		end_test("configure both masters");

		press_button(3, m_sw);
		press_button(3, m_sw);
		press_button(1, m_sw);
		press_button(1, m_sw);
		press_button(1, m_sw);
		press_button(1, m_sw);
		press_button(2, m_sw);
		press_button(2, m_sw);
		press_button(2, m_sw);
		press_button(1, m_sw);
		press_button(1, m_sw);
		press_button(1, m_sw);
		press_button(2, m_sw);
		end_test("slave stepping");

		press_button(3, random_switches());
		press_button(3, m_sw);
		press_button(3, random_switches());
		press_button(3, 12'hFFF);
		press_button(3, 12'hFFF);
		end_test("burst ceiling");

		set_mode(1'b1);
		set_rw(1'b1, 1'b0);
		press_button(1, random_switches());
		press_button(2, m_sw);
		set_rw(1'b0, 1'b1);
		press_button(1, m_sw);
		press_button(2, m_sw);
		press_button(3, m_sw);
		end_test("run mode strobes");

		set_mode(1'b0);
		press_button(3, m_sw);
		press_button(1, m_sw);
		press_button(3, m_sw);
		press_button(1, m_sw);
		press_button(3, random_switches());
		press_button(3, m_sw);
		set_mode(1'b1);
		set_mode(1'b0);
		configure(2'd2, 0, random_switches(), random_switches(), random_switches());
		end_test("run mode discards scratch");

		assert_errs = i_bus_console_top.i_bus_console_props.fail_count;
		$display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
			test_num, tests_failed, check_count, err_count, assert_errs);
		if (err_count == 0 && assert_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: test/bus_console_props.sv
// Bus console assertions
// Strobe exclusivity, one-cycle strobes and legal configuration state

`timescale 1ns/1ns

module bus_console_props
(
	input logic       reset,  // board clock
	input logic       clk,    // asynchronous reset, active high
	input logic       read1,
	input logic       write1,
	input logic       read2,
	input logic       write2,
	input logic [3:0] display_val4
);

	int fail_count = 0;

	rw1_exclusive: assert property (@(posedge reset) disable iff (clk) !(read1 && write1))
	else
	begin
		$error("read1 and write1 high in the same cycle");
		fail_count++;
	end

	rw2_exclusive: assert property (@(posedge reset) disable iff (clk) !(read2 && write2))
	else
	begin
		$error("read2 and write2 high in the same cycle");
		fail_count++;
	end

	read1_single: assert property (@(posedge reset) disable iff (clk) read1 |=> !read1)
	else
	begin
		$error("read1 high for more than one cycle");
		fail_count++;
	end

	write1_single: assert property (@(posedge reset) disable iff (clk) write1 |=> !write1)
	else
	begin
		$error("write1 high for more than one cycle");
		fail_count++;
	end

	read2_single: assert property (@(posedge reset) disable iff (clk) read2 |=> !read2)
	else
	begin
		$error("read2 high for more than one cycle");
		fail_count++;
	end

	write2_single: assert property (@(posedge reset) disable iff (clk) write2 |=> !write2)
	else
	begin
		$error("write2 high for more than one cycle");
		fail_count++;
	end

	// digit 4 value mirrors the FSM state code
	state_legal: assert property (@(posedge reset) disable iff (clk) display_val4 <= 4'd6)
	else
	begin
		$error("configuration state outside the seven legal steps");
		fail_count++;
	end

endmodule

// File: src/bus_console_top.sv
// Bus console top level
// Operator console for the two-master bus board: panel input,
// command configuration and seven-segment display stages

`timescale 1ns/1ns

`include "console_settings.svh"

module bus_console_top
(
	input  logic                  reset,
	input  logic                  clk,
	input  logic                  button1,
	input  logic                  button2,
	input  logic                  button3,
	input  logic                  mode_switch,
	input  logic                  rw_switch1,
	input  logic                  rw_switch2,
	input  logic [`ADDR_LEN-1:0]  switch_array,
	output logic [6:0]            display1_pin,
	output logic [6:0]            display2_pin,
	output logic [6:0]            display3_pin,
	output logic [6:0]            display4_pin,
	output logic [3:0]            display_val4,
	output logic                  read1,
	output logic                  write1,
	output logic                  read2,
	output logic                  write2,
	output logic [`SLAVE_LEN-1:0] slave1,
	output logic [`ADDR_LEN:0]    address1,
	output logic [`DATA_LEN-1:0]  data1,
	output logic [`BURST_LEN-1:0] burst_num1,
	output logic [`SLAVE_LEN-1:0] slave2,
	output logic [`ADDR_LEN:0]    address2,
	output logic [`DATA_LEN-1:0]  data2,
	output logic [`BURST_LEN-1:0] burst_num2
);

	bus_console_pkg::bus_cmd_t cmd1;
	bus_console_pkg::bus_cmd_t cmd2;

	panel_if   i_panel_if ();
	display_if i_display_if ();

	panel_input i_panel_input
	(
		.reset(reset), .clk(clk),
		.button1(button1), .button2(button2), .button3(button3),
		.mode_switch(mode_switch), .rw_switch1(rw_switch1), .rw_switch2(rw_switch2),
		.switch_array(switch_array),
		.panel(i_panel_if.source)
	);

	command_processor i_command_processor
	(
		.reset(reset), .clk(clk),
		.panel(i_panel_if.sink), .view(i_display_if.source),
		.read1(read1), .write1(write1), .read2(read2), .write2(write2),
		.cmd1(cmd1), .cmd2(cmd2)
	);

	display_driver i_display_driver
	(
		.reset(reset), .clk(clk),
		.view(i_display_if.sink),
		.display1_pin(display1_pin), .display2_pin(display2_pin),
		.display3_pin(display3_pin), .display4_pin(display4_pin),
		.display_val4(display_val4)
	);

	assign slave1     = cmd1.slave;
	assign address1   = cmd1.address;
	assign data1      = cmd1.data;
	assign burst_num1 = cmd1.burst_num;
	assign slave2     = cmd2.slave;
	assign address2   = cmd2.address;
	assign data2      = cmd2.data;
	assign burst_num2 = cmd2.burst_num;

endmodule

// File: src/display_driver.sv
// Display driver
// Chooses the four digit values for the current configuration step
// and feeds them to the seven-segment encoders

`timescale 1ns/1ns

module display_driver
(
	input  logic       reset,
	input  logic       clk,
	display_if.sink    view,
	output logic [6:0] display1_pin,
	output logic [6:0] display2_pin,
	output logic [6:0] display3_pin,
	output logic [6:0] display4_pin,
	output logic [3:0] display_val4
);

	logic [3:0] val1;
	logic [3:0] val2;
	logic [3:0] val3;
	logic [3:0] val4;

	// idle covers run mode as well, so everything reads 0 there
	always_comb
	begin
		val1 = 4'h0;
		val2 = 4'h0;
		val3 = 4'h0;
		case (view.state)
			bus_console_pkg::select_master: val1 = {2'b00, view.master};
			bus_console_pkg::select_slave:  val1 = 4'(view.slave);
			bus_console_pkg::select_address, bus_console_pkg::select_burst:
			begin
				val1 = view.switches[3:0];
				val2 = view.switches[7:4];
				val3 = view.switches[11:8];
			end
			bus_console_pkg::select_data:
			begin
				val1 = view.switches[3:0];
				val2 = view.switches[7:4];
			end
			default: ;
		endcase
	end

	assign val4         = {1'b0, view.state};
	assign display_val4 = val4;  // for an external LCD

	seven_seg_encoder i_digit1 (.reset(reset), .clk(clk), .nibble(val1), .seven(display1_pin));
	seven_seg_encoder i_digit2 (.reset(reset), .clk(clk), .nibble(val2), .seven(display2_pin));
	seven_seg_encoder i_digit3 (.reset(reset), .clk(clk), .nibble(val3), .seven(display3_pin));
	seven_seg_encoder i_digit4 (.reset(reset), .clk(clk), .nibble(val4), .seven(display4_pin));

endmodule

// File: src/seven_seg_encoder.sv
// Seven-segment encoder
// Registered hex digit decoder, active-high segments, bit 0 is a, bit 6 is g

`timescale 1ns/1ns

module seven_seg_encoder
(
	input  logic       reset,
	input  logic       clk,
	input  logic [3:0] nibble,
	output logic [6:0] seven
);

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			seven <= 7'h3F;  // shows 0
		else
		begin
			case (nibble)
				4'h0: seven <= 7'h3F;
				4'h1: seven <= 7'h06;
				4'h2: seven <= 7'h5B;
				4'h3: seven <= 7'h4F;
				4'h4: seven <= 7'h66;
				4'h5: seven <= 7'h6D;
				4'h6: seven <= 7'h7D;
				4'h7: seven <= 7'h07;
				4'h8: seven <= 7'h7F;
				4'h9: seven <= 7'h6F;
				4'hA: seven <= 7'h77;
				4'hB: seven <= 7'h7C;
				4'hC: seven <= 7'h39;
				4'hD: seven <= 7'h5E;
				4'hE: seven <= 7'h79;
				default: seven <= 7'h71;
			endcase
		end
	end

endmodule

// File: src/command_processor.sv
// Command processor
// Configuration FSM that builds a bus command for either master from
// button presses, and turns presses into read/write strobes in run mode

`timescale 1ns/1ns

`include "console_settings.svh"

module command_processor
(
	input  logic                      reset,
	input  logic                      clk,
	panel_if.sink                     panel,
	display_if.source                 view,
	output logic                      read1,
	output logic                      write1,
	output logic                      read2,
	output logic                      write2,
	output bus_console_pkg::bus_cmd_t cmd1,
	output bus_console_pkg::bus_cmd_t cmd2
);

	bus_console_pkg::config_state_e state;
	bus_console_pkg::master_sel_e   master;
	bus_console_pkg::bus_cmd_t      scratch;
	logic                           any_press;

	// slave 1, address 0, data 0, burst 1
	function automatic bus_console_pkg::bus_cmd_t default_cmd();
		bus_console_pkg::bus_cmd_t c;
		c.slave     = `SLAVE_LEN'(1);
		c.address   = '0;
		c.data      = '0;
		c.burst_num = `BURST_LEN'(1);
		return c;
	endfunction

	assign any_press = panel.press1 | panel.press2 | panel.press3;

	// run mode strobes
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			read1  <= 1'b0;
			write1 <= 1'b0;
			read2  <= 1'b0;
			write2 <= 1'b0;
		end
		else
		begin
			read1  <= panel.mode & panel.press1 & panel.rw1;
			write1 <= panel.mode & panel.press1 & ~panel.rw1;
			read2  <= panel.mode & panel.press2 & panel.rw2;
			write2 <= panel.mode & panel.press2 & ~panel.rw2;
		end
	end

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			state   <= bus_console_pkg::idle_config;
			master  <= bus_console_pkg::master_one;
			scratch <= default_cmd();
			cmd1    <= default_cmd();
			cmd2    <= default_cmd();
		end
		else if (panel.mode)
		begin
			// leaving config mode drops whatever was entered
			state   <= bus_console_pkg::idle_config;
			master  <= bus_console_pkg::master_one;
			scratch <= default_cmd();
		end
		else
		begin
			case (state)
				bus_console_pkg::idle_config:
				begin
					master  <= bus_console_pkg::master_one;
					scratch <= default_cmd();
					if (any_press)
						state <= bus_console_pkg::select_master;
				end
				bus_console_pkg::select_master:
				begin
					if (panel.press3)
						state <= bus_console_pkg::select_slave;
					else if (panel.press1 | panel.press2)
						master <= (master == bus_console_pkg::master_one) ?
							bus_console_pkg::master_two : bus_console_pkg::master_one;
				end
				bus_console_pkg::select_slave:
				begin
					if (panel.press3)
						state <= bus_console_pkg::select_address;
					else if (panel.press1)
					begin
						if (scratch.slave >= `SLAVE_LEN'(`SLAVE_NUM))
							scratch.slave <= '0;
						else
							scratch.slave <= scratch.slave + `SLAVE_LEN'(1);
					end
					else if (panel.press2)
					begin
						// 0 and 1 both step down to the top slave
						if (scratch.slave <= `SLAVE_LEN'(1))
							scratch.slave <= `SLAVE_LEN'(`SLAVE_NUM);
						else
							scratch.slave <= scratch.slave - `SLAVE_LEN'(1);
					end
				end
				bus_console_pkg::select_address:
				begin
					if (any_press)
					begin
						scratch.address <= {1'b0, panel.switches};
						state           <= bus_console_pkg::select_data;
					end
				end
				bus_console_pkg::select_data:
				begin
					if (any_press)
					begin
						scratch.data <= panel.switches[`DATA_LEN-1:0];
						state        <= bus_console_pkg::select_burst;
					end
				end
				bus_console_pkg::select_burst:
				begin
					if (any_press)
					begin
						if (`BURST_LEN'(panel.switches) >= `BURST_LEN'(`BURST_MAX))
							scratch.burst_num <= `BURST_LEN'(`BURST_MAX);
						else
							scratch.burst_num <= `BURST_LEN'(panel.switches);
						state <= bus_console_pkg::finish;
					end
				end
				bus_console_pkg::finish:
				begin
					if (any_press)
					begin
						if (master == bus_console_pkg::master_one)
							cmd1 <= scratch;
						else
							cmd2 <= scratch;
						state   <= bus_console_pkg::idle_config;
						master  <= bus_console_pkg::master_one;
						scratch <= default_cmd();
					end
				end
				default:
				begin
					state <= bus_console_pkg::idle_config;
				end
			endcase
		end
	end

	assign view.state    = state;
	assign view.master   = master;
	assign view.slave    = scratch.slave;
	assign view.switches = panel.switches;

endmodule

// File: src/panel_input.sv
// Panel input stage
// Two-flop synchronizers on all operator inputs, plus rising-edge
// detection that turns each button press into a single-cycle pulse

`timescale 1ns/1ns

`include "console_settings.svh"

module panel_input
(
	input  logic                 reset,
	input  logic                 clk,
	input  logic                 button1,
	input  logic                 button2,
	input  logic                 button3,
	input  logic                 mode_switch,
	input  logic                 rw_switch1,
	input  logic                 rw_switch2,
	input  logic [`ADDR_LEN-1:0] switch_array,
	panel_if.source              panel
);

	logic [2:0]           btn_meta;
	logic [2:0]           btn_sync;
	logic [2:0]           btn_prev;
	logic [2:0]           press_q;
	logic [2:0]           lvl_meta;
	logic [2:0]           lvl_sync;
	logic [`ADDR_LEN-1:0] sw_meta;
	logic [`ADDR_LEN-1:0] sw_sync;

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			btn_meta <= '0;
			btn_sync <= '0;
			btn_prev <= '0;
			press_q  <= '0;
			lvl_meta <= '0;
			lvl_sync <= '0;
			sw_meta  <= '0;
			sw_sync  <= '0;
		end
		else
		begin
			btn_meta <= {button3, button2, button1};
			btn_sync <= btn_meta;
			btn_prev <= btn_sync;
			press_q  <= btn_sync & ~btn_prev;  // held button gives one pulse
			lvl_meta <= {rw_switch2, rw_switch1, mode_switch};
			lvl_sync <= lvl_meta;
			sw_meta  <= switch_array;
			sw_sync  <= sw_meta;
		end
	end

	assign panel.press1   = press_q[0];
	assign panel.press2   = press_q[1];
	assign panel.press3   = press_q[2];
	assign panel.mode     = lvl_sync[0];
	assign panel.rw1      = lvl_sync[1];
	assign panel.rw2      = lvl_sync[2];
	assign panel.switches = sw_sync;

endmodule

// File: src/display_if.sv
// Display interface
// Configuration view passed from the command FSM to the digit driver

`timescale 1ns/1ns

`include "console_settings.svh"

interface display_if;

	bus_console_pkg::config_state_e state;
	bus_console_pkg::master_sel_e   master;
	logic [`SLAVE_LEN-1:0]          slave;
	logic [`ADDR_LEN-1:0]           switches;

	modport source (output state, master, slave, switches);
	modport sink (input state, master, slave, switches);

endinterface

// File: src/panel_if.sv
// Panel interface
// Conditioned operator inputs, button pulses and synchronized levels

`timescale 1ns/1ns

`include "console_settings.svh"

interface panel_if;

	logic                 press1;    // one-cycle pulses
	logic                 press2;
	logic                 press3;
	logic                 mode;      // 1 is run
	logic                 rw1;
	logic                 rw2;
	logic [`ADDR_LEN-1:0] switches;

	modport source (output press1, press2, press3, mode, rw1, rw2, switches);
	modport sink (input press1, press2, press3, mode, rw1, rw2, switches);

endinterface

// File: src/bus_console_pkg.sv
// Bus console types
// Configuration steps, master selection and the per-master bus command

`include "console_settings.svh"

package bus_console_pkg;

	// operator configuration steps, shown on digit 4
	typedef enum logic [2:0]
	{
		idle_config    = 3'd0,
		select_master  = 3'd1,
		select_slave   = 3'd2,
		select_address = 3'd3,
		select_data    = 3'd4,
		select_burst   = 3'd5,
		finish         = 3'd6
	} config_state_e;

	typedef enum logic [1:0]
	{
		master_one = 2'd1,
		master_two = 2'd2
	} master_sel_e;

	typedef struct packed
	{
		logic [`SLAVE_LEN-1:0] slave;
		logic [`ADDR_LEN:0]    address;  // one spare bit above the switch width
		logic [`DATA_LEN-1:0]  data;
		logic [`BURST_LEN-1:0] burst_num;
	} bus_cmd_t;

endpackage

// File: src/console_settings.svh
// Bus console settings
// Field widths and limits fixed by the board's switch array and slave count

`ifndef CONSOLE_SETTINGS_SVH
`define CONSOLE_SETTINGS_SVH

// switch array and address width
`define ADDR_LEN 12
// write data width
`define DATA_LEN 8
// burst count register width
`define BURST_LEN 13
// slave select width
`define SLAVE_LEN 2
// highest slave number on the bus
`define SLAVE_NUM 3
// burst length ceiling
`define BURST_MAX 4095

`endif
